/* Bender.yml */
package:
  name: gauntlet_loader

export_include_dirs:
  - .

sources:
  # RTL in compile order
  - files:
      - gauntlet_loader_pkg.sv
      - rom_region_decode.sv
      - rom_download_writer.sv
      - rom_bank_store.sv
      - rom_read_port.sv
      - gauntlet_loader_top.sv

  # Testbench
  - target: test
    files:
      - tb_clk_gen.sv
      - gauntlet_loader_checker.sv
      - tb_gauntlet_loader.sv

/* gauntlet_loader_checker.sv */
`timescale 1ns/1ps

module gauntlet_loader_checker (
	input logic       clk_sys,
	input logic       rst_n,
	input logic       gfx_we,
	input logic [9:0] bank_we
);

	int fail_count = 0;   // Assertion failures so far

	// One dword per four bytes, never back to back
	a_gfx_we_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		gfx_we |=> !gfx_we)
	else begin
		fail_count++;
		$error("gfx_we high on two consecutive cycles");
	end

	// Graphics and bank writes come from different bytes
	a_bank_gfx_apart: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(gfx_we && (|bank_we)))
	else begin
		fail_count++;
		$error("bank_we high together with gfx_we");
	end

endmodule

bind rom_download_writer gauntlet_loader_checker i_checker (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.gfx_we  (gfx_we),
	.bank_we (bank_we)
);

/* gauntlet_loader_consts.svh */
`ifndef GAUNTLET_LOADER_CONSTS_SVH
`define GAUNTLET_LOADER_CONSTS_SVH

// Download stream widths
`define LDR_ADDR_W    25
`define LDR_DATA_W    8

// CPU side read widths
`define PRG_ADDR_W    19    // 16-bit program words
`define AUD_ADDR_W    16
`define CHR_ADDR_W    14
`define GFX_ADDR_W    23    // Dword index into graphics memory

// Host download indices
`define IDX_ROM       8'd0
`define IDX_SLAP      8'd1
`define IDX_DIP       8'd254

`define SLAP_DEFAULT  8'd104  // Gauntlet protection chip

// ########################################
// Load map, byte addresses of the ROM stream
// ########################################
`define MAP_GFX_END   25'h0BFFFF  // Last graphics byte
`define MAP_PRG_9AB   25'h0C0000
`define MAP_PRG_10AB  25'h0F0000  // Half size bank
`define MAP_PRG_7AB   25'h100000
`define MAP_PRG_6AB   25'h110000
`define MAP_PRG_5AB   25'h120000
`define MAP_PRG_3AB   25'h130000
`define MAP_AUD_16S   25'h140000
`define MAP_AUD_16R   25'h148000
`define MAP_CHR_6P    25'h14C000

`endif

/* gauntlet_loader_pkg.sv */
package gauntlet_loader_pkg;

`include "gauntlet_loader_consts.svh"

	// Destination of one download byte
	typedef enum logic [3:0] {
		REG_NONE,
		REG_GFX,
		REG_PRG_9AB,   // Program banks in CPU order
		REG_PRG_10AB,
		REG_PRG_7AB,
		REG_PRG_6AB,
		REG_PRG_5AB,
		REG_PRG_3AB,
		REG_AUD_16S,
		REG_AUD_16R,
		REG_CHR_6P,
		REG_DIP,
		REG_SLAP
	} rom_region_e;

	// Graphics view, four bytes per dword
	typedef struct packed {
		logic [`GFX_ADDR_W-1:0] dword;
		logic [1:0]             lane;
	} ldr_gfx_t;

	// Program view, 64 KB blocks of byte pairs
	typedef struct packed {
		logic [8:0]  blk;
		logic [14:0] word;
		logic        lane;  // High on the second byte of a word
	} ldr_prg_t;

	typedef union packed {
		ldr_gfx_t gfx;
		ldr_prg_t prg;
	} ldr_addr_u;

endpackage

/* gauntlet_loader_top.sv */
`timescale 1ns/1ps
`include "gauntlet_loader_consts.svh"

module gauntlet_loader_top (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	// Host download stream
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  logic [`LDR_ADDR_W-1:0] ioctl_addr,
	input  logic [`LDR_DATA_W-1:0] ioctl_dout,
	output logic                   ioctl_wait,
	// Graphics memory
	output logic                   gfx_we,
	output logic [`GFX_ADDR_W-1:0] gfx_addr,
	output logic [31:0]            gfx_data,
	input  logic                   gfx_ready,
	// CPU reads
	input  logic [`PRG_ADDR_W-1:0] prg_addr,
	input  logic [`AUD_ADDR_W-1:0] aud_addr,
	input  logic [`CHR_ADDR_W-1:0] chr_addr,
	output logic [15:0]            prg_data,
	output logic [7:0]             aud_data,
	output logic [7:0]             chr_data,
	// Captured config
	output logic [63:0]            dip_sw,
	output logic [7:0]             slap_type
);

	logic                             wr_strobe;
	gauntlet_loader_pkg::rom_region_e wr_region;
	gauntlet_loader_pkg::ldr_addr_u   wr_addr;
	logic [`LDR_DATA_W-1:0]           wr_byte;
	logic [9:0]                       bank_we;
	logic [14:0]                      bank_waddr;
	logic [15:0]                      bank_wdata;

	assign ioctl_wait = ~gfx_ready;   // Host stalls while memory is busy

	rom_region_decode i_decode (
		.clk_sys, .rst_n,
		.ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.wr_strobe, .wr_region, .wr_addr, .wr_byte
	);

	rom_download_writer i_writer (
		.clk_sys, .rst_n,
		.wr_strobe, .wr_region, .wr_addr, .wr_byte,
		.bank_we, .bank_waddr, .bank_wdata,
		.gfx_we, .gfx_addr, .gfx_data,
		.dip_sw, .slap_type
	);

	rom_read_port i_read (
		.clk_sys, .rst_n,
		.bank_we, .bank_waddr, .bank_wdata,
		.prg_addr, .aud_addr, .chr_addr,
		.prg_data, .aud_data, .chr_data
	);

endmodule

/* rom_bank_store.sv */
`timescale 1ns/1ps

module rom_bank_store #(
	parameter int ADDR_W = 15,
	parameter int DATA_W = 16
) (
	input  logic              clk_sys,
	input  logic              we,       // Download side
	input  logic [ADDR_W-1:0] waddr,
	input  logic [DATA_W-1:0] wdata,
	input  logic [ADDR_W-1:0] raddr,    // CPU side
	output logic [DATA_W-1:0] rdata
);

	// Block RAM, one write port and one read port
	logic [DATA_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read, old data on a same address collision
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

endmodule

/* rom_download_writer.sv */
`timescale 1ns/1ps
`include "gauntlet_loader_consts.svh"

module rom_download_writer (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            wr_strobe,
	input  gauntlet_loader_pkg::rom_region_e wr_region,
	input  gauntlet_loader_pkg::ldr_addr_u  wr_addr,
	input  logic [`LDR_DATA_W-1:0]          wr_byte,
	output logic [9:0]                      bank_we,     // Bit n is region n+1
	output logic [14:0]                     bank_waddr,
	output logic [15:0]                     bank_wdata,
	output logic                            gfx_we,
	output logic [`GFX_ADDR_W-1:0]          gfx_addr,
	output logic [31:0]                     gfx_data,
	output logic [63:0]                     dip_sw,
	output logic [7:0]                      slap_type
);

	logic [23:0] hist;    // Last three ROM bytes, oldest on top
	logic        is_rom;

	assign is_rom = wr_strobe && (wr_region inside
		{[gauntlet_loader_pkg::REG_GFX:gauntlet_loader_pkg::REG_CHR_6P]});

	// ########################################
	// Byte history
	// ########################################
	always_ff @(posedge clk_sys) begin
		if (is_rom)
			hist <= {hist[15:0], wr_byte};
	end

	// ########################################
	// Bank writes, same cycle as wr_strobe
	// ########################################
	always_comb begin
		bank_we    = '0;
		bank_waddr = wr_addr.prg.word;                  // Word address
		bank_wdata = {hist[7:0], wr_byte};              // Even byte high
		if (wr_strobe) begin
			case (wr_region)
				gauntlet_loader_pkg::REG_PRG_9AB, gauntlet_loader_pkg::REG_PRG_10AB,
				gauntlet_loader_pkg::REG_PRG_7AB, gauntlet_loader_pkg::REG_PRG_6AB,
				gauntlet_loader_pkg::REG_PRG_5AB, gauntlet_loader_pkg::REG_PRG_3AB:
					bank_we[wr_region - 4'd1] = wr_addr.prg.lane;  // Odd byte closes word
				gauntlet_loader_pkg::REG_AUD_16S, gauntlet_loader_pkg::REG_AUD_16R,
				gauntlet_loader_pkg::REG_CHR_6P: begin
					// Byte wide banks
					bank_we[wr_region - 4'd1] = 1'b1;
					bank_waddr = {wr_addr.prg.word[13:0], wr_addr.prg.lane};
					bank_wdata = {8'h00, wr_byte};
				end
				default: ;
			endcase
		end
	end

	// ########################################
	// Graphics dwords and config capture
	// ########################################
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			gfx_we    <= 1'b0;
			dip_sw    <= '0;
			slap_type <= `SLAP_DEFAULT;
		end else begin
			gfx_we <= wr_strobe && wr_region == gauntlet_loader_pkg::REG_GFX &&
				wr_addr.gfx.lane == 2'd3;                   // Fourth byte of a dword
			if (wr_strobe && wr_region == gauntlet_loader_pkg::REG_DIP)
				dip_sw[wr_addr[2:0]*8 +: 8] <= wr_byte;
			if (wr_strobe && wr_region == gauntlet_loader_pkg::REG_SLAP)
				slap_type <= wr_byte;                       // Taken as is
		end
		if (wr_strobe && wr_region == gauntlet_loader_pkg::REG_GFX) begin
			gfx_addr <= wr_addr.gfx.dword;
			gfx_data <= {hist, wr_byte};
		end
	end

endmodule

/* rom_read_port.sv */
`timescale 1ns/1ps
`include "gauntlet_loader_consts.svh"

module rom_read_port (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic [9:0]             bank_we,
	input  logic [14:0]            bank_waddr,
	input  logic [15:0]            bank_wdata,
	input  logic [`PRG_ADDR_W-1:0] prg_addr,
	input  logic [`AUD_ADDR_W-1:0] aud_addr,
	input  logic [`CHR_ADDR_W-1:0] chr_addr,
	output logic [15:0]            prg_data,
	output logic [7:0]             aud_data,
	output logic [7:0]             chr_data
);

	localparam int PRG_BANK_W  = 15;   // 32K words
	localparam int PRG_SMALL_W = 14;   // 10A/10B only

	logic [15:0] prg_q [6];
	logic [2:0]  prg_sel_d;
	logic [2:0]  prg_sel_q;            // 0 means unmapped
	logic        aud_hi_q;
	logic [7:0]  aud_q_16s;
	logic [7:0]  aud_q_16r;

	// ########################################
	// Program banks 9AB 10AB 7AB 6AB 5AB 3AB
	// ########################################
	for (genvar i = 0; i < 6; i++) begin : g_prg
		localparam int AW = (i == 1) ? PRG_SMALL_W : PRG_BANK_W;
		rom_bank_store #(.ADDR_W(AW), .DATA_W(16)) i_bank (
			.clk_sys (clk_sys),
			.we      (bank_we[i+1]),    // Regions follow in bank order
			.waddr   (bank_waddr[AW-1:0]),
			.wdata   (bank_wdata),
			.raddr   (prg_addr[AW-1:0]),
			.rdata   (prg_q[i])
		);
	end

	// Bank from the CPU's upper word address bits
	always_comb begin
		prg_sel_d = 3'd0;
		if (prg_addr[18:15] == 4'b0000)       prg_sel_d = 3'd1;
		else if (prg_addr[18:14] == 5'b00110) prg_sel_d = 3'd2;
		else if (prg_addr[18:15] == 4'b0100)  prg_sel_d = 3'd3;
		else if (prg_addr[18:15] == 4'b0101)  prg_sel_d = 3'd4;
		else if (prg_addr[18:15] == 4'b0110)  prg_sel_d = 3'd5;
		else if (prg_addr[18:15] == 4'b0111)  prg_sel_d = 3'd6;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			prg_sel_q <= 3'd0;
			aud_hi_q  <= 1'b0;
		end else begin
			prg_sel_q <= prg_sel_d;   // Lines up with the bank read
			aud_hi_q  <= aud_addr[15];
		end
	end

	always_comb begin
		case (prg_sel_q)
			3'd1:    prg_data = prg_q[0];
			3'd2:    prg_data = prg_q[1];
			3'd3:    prg_data = prg_q[2];
			3'd4:    prg_data = prg_q[3];
			3'd5:    prg_data = prg_q[4];
			3'd6:    prg_data = prg_q[5];
			default: prg_data = 16'h0000;   // Filler blocks
		endcase
	end

	// ########################################
	// Audio and character
	// ########################################
	rom_bank_store #(.ADDR_W(15), .DATA_W(8)) i_aud_16s (
		.clk_sys (clk_sys),
		.we      (bank_we[7]),
		.waddr   (bank_waddr),
		.wdata   (bank_wdata[7:0]),
		.raddr   (aud_addr[14:0]),
		.rdata   (aud_q_16s)
	);

	rom_bank_store #(.ADDR_W(14), .DATA_W(8)) i_aud_16r (
		.clk_sys (clk_sys),
		.we      (bank_we[8]),
		.waddr   (bank_waddr[13:0]),
		.wdata   (bank_wdata[7:0]),
		.raddr   (aud_addr[13:0]),
		.rdata   (aud_q_16r)
	);

	rom_bank_store #(.ADDR_W(`CHR_ADDR_W), .DATA_W(8)) i_chr_6p (
		.clk_sys (clk_sys),
		.we      (bank_we[9]),
		.waddr   (bank_waddr[`CHR_ADDR_W-1:0]),
		.wdata   (bank_wdata[7:0]),
		.raddr   (chr_addr),
		.rdata   (chr_data)
	);

	assign aud_data = aud_hi_q ? aud_q_16s : aud_q_16r;  // 16S sits in the upper half

endmodule

/* rom_region_decode.sv */
`timescale 1ns/1ps
`include "gauntlet_loader_consts.svh"

module rom_region_decode (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            ioctl_download,
	input  logic                            ioctl_wr,
	input  logic [7:0]                      ioctl_index,
	input  logic [`LDR_ADDR_W-1:0]          ioctl_addr,
	input  logic [`LDR_DATA_W-1:0]          ioctl_dout,
	output logic                            wr_strobe,
	output gauntlet_loader_pkg::rom_region_e wr_region,
	output gauntlet_loader_pkg::ldr_addr_u  wr_addr,
	output logic [`LDR_DATA_W-1:0]          wr_byte
);

	localparam logic [`LDR_ADDR_W-1:0] SZ_16K = 25'h004000;
	localparam logic [`LDR_ADDR_W-1:0] SZ_32K = 25'h008000;
	localparam logic [`LDR_ADDR_W-1:0] SZ_64K = 25'h010000;

	gauntlet_loader_pkg::rom_region_e region_d;

	// Half open window [base, base+size)
	function automatic logic in_win(input logic [`LDR_ADDR_W-1:0] a,
		input logic [`LDR_ADDR_W-1:0] base, input logic [`LDR_ADDR_W-1:0] size);
		return (a >= base) && (a < base + size);
	endfunction

	always_comb begin
		region_d = gauntlet_loader_pkg::REG_NONE;   // Filler and stray bytes
		if (ioctl_index == `IDX_ROM && ioctl_download) begin
			if (ioctl_addr <= `MAP_GFX_END)
				region_d = gauntlet_loader_pkg::REG_GFX;
			else if (in_win(ioctl_addr, `MAP_PRG_9AB, SZ_64K))
				region_d = gauntlet_loader_pkg::REG_PRG_9AB;
			else if (in_win(ioctl_addr, `MAP_PRG_10AB, SZ_32K))
				region_d = gauntlet_loader_pkg::REG_PRG_10AB;
			else if (in_win(ioctl_addr, `MAP_PRG_7AB, SZ_64K))
				region_d = gauntlet_loader_pkg::REG_PRG_7AB;
			else if (in_win(ioctl_addr, `MAP_PRG_6AB, SZ_64K))
				region_d = gauntlet_loader_pkg::REG_PRG_6AB;
			else if (in_win(ioctl_addr, `MAP_PRG_5AB, SZ_64K))
				region_d = gauntlet_loader_pkg::REG_PRG_5AB;
			else if (in_win(ioctl_addr, `MAP_PRG_3AB, SZ_64K))
				region_d = gauntlet_loader_pkg::REG_PRG_3AB;
			else if (in_win(ioctl_addr, `MAP_AUD_16S, SZ_32K))
				region_d = gauntlet_loader_pkg::REG_AUD_16S;
			else if (in_win(ioctl_addr, `MAP_AUD_16R, SZ_16K))
				region_d = gauntlet_loader_pkg::REG_AUD_16R;
			else if (in_win(ioctl_addr, `MAP_CHR_6P, SZ_16K))
				region_d = gauntlet_loader_pkg::REG_CHR_6P;
		end else if (ioctl_index == `IDX_DIP && ioctl_addr < 25'd8) begin
			region_d = gauntlet_loader_pkg::REG_DIP;          // Eight switch bytes
		end else if (ioctl_index == `IDX_SLAP) begin
			region_d = gauntlet_loader_pkg::REG_SLAP;
		end
	end

	// One stage, no stall
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_strobe <= 1'b0;
			wr_region <= gauntlet_loader_pkg::REG_NONE;
		end else begin
			wr_strobe <= ioctl_wr;
			wr_region <= region_d;
		end
		wr_addr <= ioctl_addr;  // Payload travels alongside
		wr_byte <= ioctl_dout;
	end

endmodule

/* sources.f */
+incdir+.
gauntlet_loader_pkg.sv
rom_region_decode.sv
rom_download_writer.sv
rom_bank_store.sv
rom_read_port.sv
gauntlet_loader_top.sv
tb_clk_gen.sv
gauntlet_loader_checker.sv
tb_gauntlet_loader.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	// 100 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Reset held over 16 rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

/* tb_gauntlet_loader.sv */
`timescale 1ns/1ps
`include "gauntlet_loader_consts.svh"

module tb_gauntlet_loader;

	localparam int MAX_ROWS = 48;
	localparam int WAIT_MAX = 200;   // Cycles per wait
	localparam int K_PRG    = 0;
	localparam int K_AUD    = 1;
	localparam int K_CHR    = 2;
	localparam int K_GFX    = 3;
	localparam int K_DIP    = 4;
	localparam int K_SLAP   = 5;

	logic                   clk_sys;
	logic                   rst_n;
	logic                   ioctl_download;
	logic                   ioctl_wr;
	logic [7:0]             ioctl_index;
	logic [`LDR_ADDR_W-1:0] ioctl_addr;
	logic [`LDR_DATA_W-1:0] ioctl_dout;
	logic                   ioctl_wait;
	logic                   gfx_we;
	logic [`GFX_ADDR_W-1:0] gfx_addr;
	logic [31:0]            gfx_data;
	logic                   gfx_ready;
	logic [`PRG_ADDR_W-1:0] prg_addr;
	logic [`AUD_ADDR_W-1:0] aud_addr;
	logic [`CHR_ADDR_W-1:0] chr_addr;
	logic [15:0]            prg_data;
	logic [7:0]             aud_data;
	logic [7:0]             chr_data;
	logic [63:0]            dip_sw;
	logic [7:0]             slap_type;

	// ########################################
	// Stimulus and expect table
	// ########################################
	int          row_test [MAX_ROWS];
	int          row_kind [MAX_ROWS];
	logic [7:0]  row_idx  [MAX_ROWS];
	logic [24:0] row_addr [MAX_ROWS];
	logic [31:0] row_data [MAX_ROWS];   // Bytes in send order, first on top
	logic [18:0] row_rd   [MAX_ROWS];   // CPU read address
	logic [63:0] row_exp  [MAX_ROWS];
	int          n_rows;

	logic [54:0] gfx_log [$];           // {gfx_addr, gfx_data} per pulse
	integer      seed;
	int          n_checks;
	int          n_errors;
	int          test_err [1:5];
	string       test_name [1:5];
	int          cur_test;

	tb_clk_gen i_clk (.clk_sys, .rst_n);

	gauntlet_loader_top i_dut (.*);

	// Graphics memory, busy about a quarter of the time
	always @(negedge clk_sys) begin
		gfx_ready = ($random(seed) & 3) != 0;
	end

	always @(negedge clk_sys) begin
		if (rst_n && gfx_we)
			gfx_log.push_back({gfx_addr, gfx_data});
	end

	task automatic note_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		n_errors++;
		test_err[cur_test]++;
		$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
	endtask

	task automatic timed_out(input string what);
		$display("Timeout while waiting for %s", what);
		$display("*** FAILED ***");
		$finish;
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s: %0d errors", t, test_name[t], test_err[t]);
	endtask

	// Host side, one byte once ioctl_wait is low at a rising edge
	task automatic send_byte(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		int n;
		for (n = 0; n <= WAIT_MAX; n++) begin
			@(posedge clk_sys);
			if (ioctl_wait !== !gfx_ready)
				note_mismatch("ioctl_wait", ioctl_wait, !gfx_ready);
			if (!ioctl_wait)
				break;
		end
		if (n > WAIT_MAX)
			timed_out("ioctl_wait to drop");
		@(negedge clk_sys);
		ioctl_wr    = 1'b1;
		ioctl_index = idx;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic wait_gfx_pulse();
		int n;
		for (n = 0; n <= WAIT_MAX; n++) begin
			@(posedge clk_sys);
			if (gfx_log.size() > 0)
				break;
		end
		if (n > WAIT_MAX)
			timed_out("a gfx_we pulse");
	endtask

	task automatic add_row(input int test, input int kind, input logic [7:0] idx,
		input logic [24:0] addr, input logic [31:0] data, input logic [18:0] rd,
		input logic [63:0] exp);
		row_test[n_rows] = test;
		row_kind[n_rows] = kind;
		row_idx[n_rows]  = idx;
		row_addr[n_rows] = addr;
		row_data[n_rows] = data;
		row_rd[n_rows]   = rd;
		row_exp[n_rows]  = exp;
		n_rows++;
	endtask

	task automatic load_table();
		logic [24:0] prg_base [6];
		logic [24:0] fill_addr [3];
		logic [24:0] a;
		logic [31:0] d;
		logic [63:0] dip;
		int i;
		prg_base  = '{`MAP_PRG_9AB, `MAP_PRG_10AB, `MAP_PRG_7AB,
			`MAP_PRG_6AB, `MAP_PRG_5AB, `MAP_PRG_3AB};
		fill_addr = '{25'h0D0000, 25'h0E1000, 25'h0F8000};   // Gaps in the load map
		n_rows = 0;
		// CPU word address is the byte offset from 9A/9B, halved
		for (i = 0; i < 12; i++) begin
			a = prg_base[i / 2];
			if (i % 2)
				a = a + ((i / 2 == 1) ? 25'h007FFE : 25'h00FFFE);   // Last word
			d = $random(seed);
			add_row(1, K_PRG, `IDX_ROM, a, d, 19'((a - `MAP_PRG_9AB) >> 1), {48'h0, d[15:0]});
		end
		for (i = 0; i < 3; i++) begin
			a = fill_addr[i];
			add_row(2, K_PRG, `IDX_ROM, a, $random(seed), 19'((a - `MAP_PRG_9AB) >> 1), 64'h0);
		end
		for (i = 0; i < 3; i++) begin
			d = $random(seed);
			a = `MAP_AUD_16S + ((i == 2) ? 25'h7FFF : 25'(i * 25'h1235));
			add_row(3, K_AUD, `IDX_ROM, a, d, 19'(16'h8000 | 16'(a - `MAP_AUD_16S)),
				{56'h0, d[7:0]});
			d = $random(seed);
			a = `MAP_AUD_16R + ((i == 2) ? 25'h3FFF : 25'(i * 25'h1235));
			add_row(3, K_AUD, `IDX_ROM, a, d, 19'(a - `MAP_AUD_16R), {56'h0, d[7:0]});
			d = $random(seed);
			a = `MAP_CHR_6P + ((i == 2) ? 25'h3FFF : 25'(i * 25'h1235));
			add_row(3, K_CHR, `IDX_ROM, a, d, 19'(a - `MAP_CHR_6P), {56'h0, d[7:0]});
		end
		for (i = 0; i < 4; i++) begin
			a = (i == 3) ? `MAP_GFX_END - 25'd3 : 25'(i * 25'h012344);
			d = $random(seed);
			add_row(4, K_GFX, `IDX_ROM, a, d, 19'h0, {9'h0, a[24:2], d});   // Dword = addr / 4
		end
		dip = 64'h0;
		for (i = 0; i < 8; i++) begin
			d = $random(seed);
			dip[i*8 +: 8] = d[7:0];
			add_row(5, K_DIP, `IDX_DIP, 25'(i), d, 19'h0, dip);
		end
		add_row(5, K_DIP, `IDX_DIP, 25'd9, 32'h5A, 19'h0, dip);   // Beyond the switch bytes
		add_row(5, K_SLAP, `IDX_SLAP, 25'd0, 32'h03, 19'h0, 64'h03);
		add_row(5, K_SLAP, `IDX_SLAP, 25'd0, 32'h6B, 19'h0, 64'h6B);
	endtask

	task automatic apply_row(input int r);
		logic [54:0] got;
		int b;
		case (row_kind[r])
			K_PRG: begin
				send_byte(row_idx[r], row_addr[r], row_data[r][15:8]);          // Even lane
				send_byte(row_idx[r], row_addr[r] + 25'd1, row_data[r][7:0]);
				@(negedge clk_sys);
				prg_addr = row_rd[r];
				@(negedge clk_sys);   // One cycle read latency
				n_checks++;
				if (prg_data !== row_exp[r][15:0])
					note_mismatch("prg_data", prg_data, row_exp[r][15:0]);
			end
			K_AUD, K_CHR: begin
				send_byte(row_idx[r], row_addr[r], row_data[r][7:0]);
				@(negedge clk_sys);
				aud_addr = row_rd[r][15:0];
				chr_addr = row_rd[r][13:0];
				@(negedge clk_sys);
				n_checks++;
				if (row_kind[r] == K_AUD && aud_data !== row_exp[r][7:0])
					note_mismatch("aud_data", aud_data, row_exp[r][7:0]);
				if (row_kind[r] == K_CHR && chr_data !== row_exp[r][7:0])
					note_mismatch("chr_data", chr_data, row_exp[r][7:0]);
			end
			K_GFX: begin
				for (b = 0; b < 4; b++)
					send_byte(row_idx[r], row_addr[r] + 25'(b), row_data[r][31 - 8*b -: 8]);
				wait_gfx_pulse();
				repeat (4) @(posedge clk_sys);   // Room for a second, wrong pulse
				n_checks++;
				if (gfx_log.size() != 1)
					note_mismatch("gfx_we pulse count", gfx_log.size(), 1);
				got = gfx_log.pop_front();
				gfx_log.delete();
				if (got[54:32] !== row_exp[r][54:32])
					note_mismatch("gfx_addr", got[54:32], row_exp[r][54:32]);
				if (got[31:0] !== row_exp[r][31:0])
					note_mismatch("gfx_data", got[31:0], row_exp[r][31:0]);
			end
			default: begin
				send_byte(row_idx[r], row_addr[r], row_data[r][7:0]);
				@(negedge clk_sys);
				n_checks++;
				if (row_kind[r] == K_DIP && dip_sw !== row_exp[r])
					note_mismatch("dip_sw", dip_sw, row_exp[r]);
				if (row_kind[r] == K_SLAP && slap_type !== row_exp[r][7:0])
					note_mismatch("slap_type", slap_type, row_exp[r][7:0]);
			end
		endcase
	endtask

	// ########################################
	// Main sequence
	// ########################################
	initial begin
		int r;
		seed           = 32'h2729882f;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = 8'h00;
		gfx_ready      = 1'b1;
		prg_addr       = '0;
		aud_addr       = '0;
		chr_addr       = '0;
		n_checks       = 0;
		n_errors       = 0;
		foreach (test_err[t])
			test_err[t] = 0;
		test_name[1] = "program words";
		test_name[2] = "unmapped program reads";
		test_name[3] = "audio and character bytes";
		test_name[4] = "graphics dwords";
		test_name[5] = "configuration capture";
		load_table();
		for (r = 0; r <= WAIT_MAX && rst_n !== 1'b1; r++)
			@(negedge clk_sys);
		if (rst_n !== 1'b1)
			timed_out("reset release");
		cur_test = 5;
		n_checks++;
		if (slap_type !== 8'd104)   // Protection type straight out of reset
			note_mismatch("slap_type", slap_type, 8'd104);
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		cur_test = row_test[0];
		for (r = 0; r < n_rows; r++) begin
			if (row_test[r] != cur_test) begin
				report_test(cur_test);
				cur_test = row_test[r];
			end
			apply_row(r);
		end
		report_test(cur_test);
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (4) @(posedge clk_sys);
		if (gfx_log.size() != 0) begin
			n_errors++;
			$display("Stray gfx_we pulses after the graphics rows");
		end
		n_errors += i_dut.i_writer.i_checker.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
			i_dut.i_writer.i_checker.fail_count);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
